/* Makefile */
# Verilator build and run for the instruction cache storage core

VERILATOR ?= verilator
TOP       ?= tb_ic_mem
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= all tests passed

SOURCES := $(wildcard hdl/*.sv hdl/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Passes only if the pass message shows up in the output
run: compile
	$(OBJ_DIR)/V$(TOP) | awk '{ print } /$(PASS_MSG)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

/* hdl/ic_data_array.sv */
/*
 * Instruction cache data array: 4 ways x 4 subbanks of 34-bit words,
 * fill and debug write decode, subbank masking and way selection
 */
`include "ic_settings.svh"

module ic_data_array (
   input  logic                        clk,
   input  logic                        rst_n,
   input  ic_pkg::ic_access_t          acc,
   input  ic_pkg::ic_debug_t           dbg,
   input  logic [`IC_NUM_WAYS-1:0]     rd_hit,
   output logic [`IC_RD_WIDTH-1:0]     rd_data
);

   logic                               dbg_active;
   logic                               dbg_data_rd;
   logic                               dbg_data_wr;
   logic [`IC_NUM_WAYS-1:0]            dbg_rd_way;
   logic [`IC_NUM_WAYS-1:0]            dbg_wr_way;
   logic [`IC_DATA_IDX_W-1:0]          ram_idx;
   logic [`IC_NUM_SUBBANKS-1:0]        sb_mask_d;
   logic [`IC_NUM_SUBBANKS-1:0]        sb_mask_q;
   logic                               dbg_rd_q;
   logic [`IC_NUM_WAYS-1:0]            dbg_way_q;
   logic [`IC_NUM_WAYS-1:0]            way_sel;

   logic [`IC_NUM_SUBBANKS-1:0][`IC_NUM_WAYS-1:0]   sb_wren;     // subbank, way
   logic [`IC_NUM_SUBBANKS-1:0][`IC_SB_WIDTH-1:0]   sb_wr_data;
   logic [`IC_NUM_WAYS-1:0][`IC_NUM_SUBBANKS-1:0][`IC_SB_WIDTH-1:0] sb_dout;

   //////////////////////////////////////////////////////////////////////
   // Request decode
   //////////////////////////////////////////////////////////////////////
   assign dbg_active  = dbg.rd_en | dbg.wr_en;
   assign dbg_data_rd = dbg.rd_en & ~dbg.tag_array;
   assign dbg_data_wr = dbg.wr_en & ~dbg.tag_array;
   assign dbg_rd_way  = {`IC_NUM_WAYS{dbg_data_rd}} & dbg.way;
   assign dbg_wr_way  = {`IC_NUM_WAYS{dbg_data_wr}} & dbg.way;

   assign ram_idx = dbg_active ? dbg.addr[`IC_TAG_HIGH-1:`IC_SB_LOW] :
                                 acc.rw_addr[`IC_TAG_HIGH-1:`IC_SB_LOW];

   for (genvar k = 0; k < `IC_NUM_SUBBANKS; k++) begin : g_sb
      localparam logic [1:0] sb_id = 2'(k);

      // Fill writes a subbank pair, debug writes a single word
      assign sb_wren[k] = (acc.wr_en  & {`IC_NUM_WAYS{acc.rw_addr[3] == sb_id[1]}}) |
                          (dbg_wr_way & {`IC_NUM_WAYS{dbg.addr[3:2] == sb_id}});

      assign sb_wr_data[k] = dbg_data_wr ? dbg.wr_data.data :
                             sb_id[0]    ? acc.wr_data[2*`IC_SB_WIDTH-1:`IC_SB_WIDTH] :
                                           acc.wr_data[`IC_SB_WIDTH-1:0];

      // Fetch drops subbanks before the start offset
      assign sb_mask_d[k] = dbg_active ? dbg_data_rd :
                                         (acc.rd_en & (sb_id >= acc.rw_addr[3:2]));

      for (genvar w = 0; w < `IC_NUM_WAYS; w++) begin : g_way
         ic_sram #(
            .width (`IC_SB_WIDTH),
            .depth (1 << `IC_DATA_IDX_W)
         ) u_ram (
            .clk   (clk),
            .we    (sb_wren[k][w]),
            .addr  (ram_idx),
            .d     (sb_wr_data[k]),
            .q     (sb_dout[w][k])
         );
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read stage registers
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sb_mask_q <= '0;
         dbg_rd_q  <= 1'b0;
         dbg_way_q <= '0;
      end else begin
         sb_mask_q <= sb_mask_d;
         dbg_rd_q  <= dbg_data_rd;
         dbg_way_q <= dbg_rd_way;
      end
   end

   assign way_sel = dbg_rd_q ? dbg_way_q : rd_hit;   // Debug way overrides hit

   //////////////////////////////////////////////////////////////////////
   // Way mux, ORed over selected ways
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      rd_data = '0;
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
         for (int k = 0; k < `IC_NUM_SUBBANKS; k++) begin
            if (way_sel[w] && sb_mask_q[k]) begin
               rd_data[k*`IC_SB_WIDTH +: `IC_SB_WIDTH] =
                  rd_data[k*`IC_SB_WIDTH +: `IC_SB_WIDTH] | sb_dout[w][k];
            end
         end
      end
   end

endmodule

/* hdl/ic_mem.sv */
/*
 * Instruction cache storage core, data and tag arrays on one access port
 */
`include "ic_settings.svh"

module ic_mem (
   input  logic                        clk,
   input  logic                        rst_n,
   input  ic_pkg::ic_access_t          acc,
   input  ic_pkg::ic_debug_t           dbg,
   input  logic [`IC_NUM_WAYS-1:0]     ic_tag_valid,         // Valid bits kept outside
   output logic [`IC_RD_WIDTH-1:0]     ic_rd_data,
   output logic [`IC_NUM_WAYS-1:0]     ic_rd_hit,
   output logic                        ic_tag_perr,
   output ic_pkg::ic_tag_entry_t       ictag_debug_rd_data
);

   //////////////////////////////////////////////////////////////////////
   // Tag array, drives way hits
   //////////////////////////////////////////////////////////////////////
   ic_tag_array u_tag (
      .clk               (clk),
      .rst_n             (rst_n),
      .acc               (acc),
      .dbg               (dbg),
      .tag_valid         (ic_tag_valid),
      .rd_hit            (ic_rd_hit),
      .tag_perr          (ic_tag_perr),
      .tag_debug_rd_data (ictag_debug_rd_data)
   );

   //////////////////////////////////////////////////////////////////////
   // Data array, selects ways by hit
   //////////////////////////////////////////////////////////////////////
   ic_data_array u_data (
      .clk               (clk),
      .rst_n             (rst_n),
      .acc               (acc),
      .dbg               (dbg),
      .rd_hit            (ic_rd_hit),
      .rd_data           (ic_rd_data)
   );

endmodule

/* hdl/ic_pkg.sv */
/*
 * Shared types for the instruction cache storage core
 */
`include "ic_settings.svh"

package ic_pkg;

   // Fill and fetch access, one per cycle
   typedef struct packed {
      logic [31:2]                   rw_addr;     // Word address
      logic                          rd_en;       // Fetch read
      logic [`IC_NUM_WAYS-1:0]       wr_en;       // Fill way enables
      logic [2*`IC_SB_WIDTH-1:0]     wr_data;     // Two subbank words per beat
   } ic_access_t;

   // Tag layout of a debug write word
   typedef struct packed {
      logic                          spare;
      logic                          parity;      // Taken as given
      logic [`IC_TAG_BITS-1:0]       tag;
      logic [`IC_TAG_HIGH-1:0]       unused;
   } ic_debug_tag_view_t;

   typedef union packed {
      logic [`IC_SB_WIDTH-1:0]       data;        // Data subbank view
      ic_debug_tag_view_t            tag;         // Tag entry view
   } ic_debug_word_u;

   typedef struct packed {
      logic [`IC_TAG_HIGH-1:2]       addr;
      logic                          rd_en;
      logic                          wr_en;
      logic                          tag_array;   // Tag array, else data array
      logic [`IC_NUM_WAYS-1:0]       way;         // One-hot
      ic_debug_word_u                wr_data;
   } ic_debug_t;

   typedef struct packed {
      logic                          parity;      // Even parity over tag
      logic [`IC_TAG_BITS-1:0]       tag;
   } ic_tag_entry_t;

endpackage

/* hdl/ic_settings.svh */
/*
 * Instruction cache storage settings: ways, subbanks, address split, widths
 */
`ifndef IC_SETTINGS_SVH
`define IC_SETTINGS_SVH

`define IC_NUM_WAYS      4                        // Set associativity
`define IC_NUM_SUBBANKS  4                        // 16B subbanks per fetch
`define IC_TAG_HIGH      12                       // Tag is addr[31:12]
`define IC_LINE_LOW      6                        // 64B line, tag index addr[11:6]
`define IC_SB_LOW        4                        // Data index addr[11:4]
`define IC_SB_WIDTH      34                       // 32 data + 2 parity
`define IC_TAG_WIDTH     21                       // Tag plus parity

// Derived widths
`define IC_TAG_BITS      (32 - `IC_TAG_HIGH)
`define IC_DATA_IDX_W    (`IC_TAG_HIGH - `IC_SB_LOW)
`define IC_TAG_IDX_W     (`IC_TAG_HIGH - `IC_LINE_LOW)
`define IC_RD_WIDTH      (`IC_NUM_SUBBANKS * `IC_SB_WIDTH)

`endif

/* hdl/ic_sram.sv */
/*
 * Generic single-port synchronous RAM, registered read data
 */
module ic_sram #(
   parameter int width = 34,
   parameter int depth = 256
) (
   input  logic                     clk,
   input  logic                     we,
   input  logic [$clog2(depth)-1:0] addr,
   input  logic [width-1:0]         d,
   output logic [width-1:0]         q
);

   logic [width-1:0] mem [depth];

   // Read returns old contents on a same-cycle write
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= d;
      end
      q <= mem[addr];
   end

endmodule

/* hdl/ic_tag_array.sv */
/*
 * Instruction cache tag array: per-way tag RAMs with even parity,
 * hit compare against the registered fetch tag and debug readout
 */
`include "ic_settings.svh"

module ic_tag_array (
   input  logic                        clk,
   input  logic                        rst_n,
   input  ic_pkg::ic_access_t          acc,
   input  ic_pkg::ic_debug_t           dbg,
   input  logic [`IC_NUM_WAYS-1:0]     tag_valid,
   output logic [`IC_NUM_WAYS-1:0]     rd_hit,
   output logic                        tag_perr,
   output ic_pkg::ic_tag_entry_t       tag_debug_rd_data
);

   logic                               dbg_active;
   logic                               dbg_tag_wr;
   logic [`IC_NUM_WAYS-1:0]            dbg_rd_way;
   logic [`IC_NUM_WAYS-1:0]            dbg_wr_way;
   logic [`IC_NUM_WAYS-1:0]            tag_wren;
   logic [`IC_TAG_IDX_W-1:0]           tag_idx;
   ic_pkg::ic_tag_entry_t              wr_entry;
   logic [`IC_TAG_BITS-1:0]            fetch_tag_q;
   logic [`IC_NUM_WAYS-1:0]            dbg_way_q;
   logic [`IC_NUM_WAYS-1:0]            way_perr;
   ic_pkg::ic_tag_entry_t [`IC_NUM_WAYS-1:0] tag_dout;

   //////////////////////////////////////////////////////////////////////
   // Write side
   //////////////////////////////////////////////////////////////////////
   assign dbg_active = dbg.rd_en | dbg.wr_en;
   assign dbg_tag_wr = dbg.wr_en & dbg.tag_array;
   assign dbg_rd_way = {`IC_NUM_WAYS{dbg.rd_en & dbg.tag_array}} & dbg.way;
   assign dbg_wr_way = {`IC_NUM_WAYS{dbg_tag_wr}} & dbg.way;

   // Tag written on the last 8B beat of the line
   assign tag_wren = (acc.wr_en & {`IC_NUM_WAYS{&acc.rw_addr[5:3]}}) | dbg_wr_way;

   assign tag_idx = dbg_active ? dbg.addr[`IC_TAG_HIGH-1:`IC_LINE_LOW] :
                                 acc.rw_addr[`IC_TAG_HIGH-1:`IC_LINE_LOW];

   always_comb begin
      if (dbg_tag_wr) begin
         wr_entry.parity = dbg.wr_data.tag.parity;   // May carry injected error
         wr_entry.tag    = dbg.wr_data.tag.tag;
      end else begin
         wr_entry.parity = ^acc.rw_addr[31:`IC_TAG_HIGH];
         wr_entry.tag    = acc.rw_addr[31:`IC_TAG_HIGH];
      end
   end

   for (genvar w = 0; w < `IC_NUM_WAYS; w++) begin : g_way
      ic_sram #(
         .width (`IC_TAG_WIDTH),
         .depth (1 << `IC_TAG_IDX_W)
      ) u_ram (
         .clk   (clk),
         .we    (tag_wren[w]),
         .addr  (tag_idx),
         .d     (wr_entry),
         .q     (tag_dout[w])
      );

      assign way_perr[w] = ^{tag_dout[w].parity, tag_dout[w].tag};
      assign rd_hit[w]   = (tag_dout[w].tag == fetch_tag_q) & tag_valid[w];
   end

   //////////////////////////////////////////////////////////////////////
   // Read side
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      fetch_tag_q <= acc.rw_addr[31:`IC_TAG_HIGH];   // Compared one cycle later
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dbg_way_q <= '0;
      end else begin
         dbg_way_q <= dbg_rd_way;
      end
   end

   assign tag_perr = |(way_perr & tag_valid);         // Only valid ways count

   always_comb begin
      tag_debug_rd_data = '0;
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
         if (dbg_way_q[w]) begin
            tag_debug_rd_data = tag_debug_rd_data | tag_dout[w];
         end
      end
   end

endmodule

/* testbench/tb_ic_mem.sv */
/*
 * Testbench for the instruction cache storage core: fills, fetches and
 * debug accesses, checked by assertions against a rule-based model
 */
`include "ic_settings.svh"

module tb_ic_mem;
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [1:0]  KIND_NONE     = 2'd0;
   localparam logic [1:0]  KIND_FETCH    = 2'd1;
   localparam logic [1:0]  KIND_DBG_DATA = 2'd2;
   localparam logic [1:0]  KIND_DBG_TAG  = 2'd3;
   localparam logic [19:0] INIT_TAG      = 20'hfffff;   // Never used by fills

   logic                               clk;
   logic                               rst_n;
   ic_pkg::ic_access_t                 acc;
   ic_pkg::ic_debug_t                  dbg;
   logic [3:0]                         tag_valid;
   logic [`IC_RD_WIDTH-1:0]            ic_rd_data;
   logic [3:0]                         ic_rd_hit;
   logic                               ic_tag_perr;
   ic_pkg::ic_tag_entry_t              ictag_debug_rd_data;

   logic [`IC_SB_WIDTH-1:0]            data_m [logic [11:0]];  // {way, index, subbank}
   ic_pkg::ic_tag_entry_t              tag_m [logic [7:0]];    // {way, set}
   logic [1:0]                         kind_q;
   logic [3:0][3:0][`IC_SB_WIDTH-1:0]  snap_data;              // way, subbank
   ic_pkg::ic_tag_entry_t [3:0]        snap_tag;
   logic [19:0]                        snap_ftag;
   logic [1:0]                         snap_off;
   logic [3:0]                         snap_way;
   logic [`IC_RD_WIDTH-1:0]            exp_rd_data;
   logic [3:0]                         exp_hit;
   logic                               exp_perr;
   ic_pkg::ic_tag_entry_t              exp_dbg_tag;

   ic_mem ic_mem_i (
      .clk                 (clk),
      .rst_n               (rst_n),
      .acc                 (acc),
      .dbg                 (dbg),
      .ic_tag_valid        (tag_valid),
      .ic_rd_data          (ic_rd_data),
      .ic_rd_hit           (ic_rd_hit),
      .ic_tag_perr         (ic_tag_perr),
      .ictag_debug_rd_data (ictag_debug_rd_data)
   );

   always #4 clk = ~clk;

   ////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////
   function automatic logic [`IC_SB_WIDTH-1:0] model_word(logic [1:0] w, logic [7:0] idx,
                                                          logic [1:0] k);
      if (data_m.exists({w, idx, k})) begin
         return data_m[{w, idx, k}];
      end
      return '0;
   endfunction

   function automatic ic_pkg::ic_tag_entry_t model_tag(logic [1:0] w, logic [5:0] set);
      if (tag_m.exists({w, set})) begin
         return tag_m[{w, set}];
      end
      return '0;
   endfunction

   always @(posedge clk) begin : model_update
      logic [7:0] didx;
      logic [5:0] tset;
      didx = (dbg.rd_en | dbg.wr_en) ? dbg.addr[11:4] : acc.rw_addr[11:4];
      tset = didx[7:2];
      if (!rst_n) begin
         kind_q <= KIND_NONE;
      end else begin
         for (int w = 0; w < 4; w++) begin          // Snapshot before this edge's writes
            snap_tag[w] <= model_tag(2'(w), tset);
            for (int k = 0; k < 4; k++) begin
               snap_data[w][k] <= model_word(2'(w), didx, 2'(k));
            end
         end
         snap_ftag <= acc.rw_addr[31:12];
         snap_off  <= acc.rw_addr[3:2];
         snap_way  <= dbg.way;
         if (dbg.rd_en) begin
            kind_q <= dbg.tag_array ? KIND_DBG_TAG : KIND_DBG_DATA;
         end else begin
            kind_q <= acc.rd_en ? KIND_FETCH : KIND_NONE;
         end
         for (int w = 0; w < 4; w++) begin
            if (acc.wr_en[w]) begin                 // Subbank pair, tag on last beat
               data_m[{2'(w), didx, acc.rw_addr[3], 1'b0}] = acc.wr_data[33:0];
               data_m[{2'(w), didx, acc.rw_addr[3], 1'b1}] = acc.wr_data[67:34];
               if (&acc.rw_addr[5:3]) begin
                  tag_m[{2'(w), tset}] = {^acc.rw_addr[31:12], acc.rw_addr[31:12]};
               end
            end
            if (dbg.wr_en && dbg.way[w] && dbg.tag_array) begin
               tag_m[{2'(w), tset}] = {dbg.wr_data.tag.parity, dbg.wr_data.tag.tag};
            end else if (dbg.wr_en && dbg.way[w]) begin
               data_m[{2'(w), didx, dbg.addr[3:2]}] = dbg.wr_data.data;
            end
         end
      end
   end

   // Hit and perr use the valid bits of the response cycle
   always_comb begin
      exp_rd_data = '0;
      exp_hit     = '0;
      exp_perr    = 1'b0;
      exp_dbg_tag = '0;
      for (int w = 0; w < 4; w++) begin
         if (kind_q == KIND_FETCH) begin
            exp_hit[w] = (snap_tag[w].tag == snap_ftag) && tag_valid[w];
            exp_perr   = exp_perr | (tag_valid[w] && (snap_tag[w].parity != ^snap_tag[w].tag));
         end
         for (int k = 0; k < 4; k++) begin
            if ((kind_q == KIND_FETCH && exp_hit[w] && 2'(k) >= snap_off) ||
                (kind_q == KIND_DBG_DATA && snap_way[w])) begin
               exp_rd_data[k*`IC_SB_WIDTH +: `IC_SB_WIDTH] =
                  exp_rd_data[k*`IC_SB_WIDTH +: `IC_SB_WIDTH] | snap_data[w][k];
            end
         end
         if (kind_q == KIND_DBG_TAG && snap_way[w]) begin
            exp_dbg_tag = snap_tag[w];
         end
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////
   task automatic report_mismatch(input string name, input logic [135:0] expected,
                                  input logic [135:0] actual);
      $display("FAIL time=%0d ns %s expected=%h actual=%h", $time, name, expected, actual);
      $display("tests failed");
      $fatal(1, "Output %s does not match the model", name);
   endtask

   a_rd_data : assert property (@(posedge clk) disable iff (!rst_n)
      ic_rd_data == exp_rd_data)
      else report_mismatch("ic_rd_data", $sampled(exp_rd_data), $sampled(ic_rd_data));
   a_dbg_tag : assert property (@(posedge clk) disable iff (!rst_n)
      ictag_debug_rd_data == exp_dbg_tag)
      else report_mismatch("ictag_debug_rd_data", 136'($sampled(exp_dbg_tag)),
                           136'($sampled(ictag_debug_rd_data)));
   a_rd_hit : assert property (@(posedge clk) disable iff (!rst_n)
      kind_q == KIND_FETCH |-> ic_rd_hit == exp_hit)
      else report_mismatch("ic_rd_hit", 136'($sampled(exp_hit)), 136'($sampled(ic_rd_hit)));
   a_perr : assert property (@(posedge clk) disable iff (!rst_n)
      kind_q == KIND_FETCH |-> ic_tag_perr == exp_perr)
      else report_mismatch("ic_tag_perr", 136'($sampled(exp_perr)),
                           136'($sampled(ic_tag_perr)));

   ////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////
   function automatic logic [19:0] rand_tag();
      logic [19:0] t;
      t = 20'($urandom);
      if (t == INIT_TAG) begin
         t = 20'h1a5c3;
      end
      return t;
   endfunction

   function automatic ic_pkg::ic_debug_word_u tag_word(logic parity, logic [19:0] tag);
      ic_pkg::ic_debug_word_u w;
      w            = '0;
      w.tag.parity = parity;
      w.tag.tag    = tag;
      return w;
   endfunction

   task automatic drive(input ic_pkg::ic_access_t a, input ic_pkg::ic_debug_t d);
      @(posedge clk);
      acc <= a;
      dbg <= d;
   endtask

   task automatic idle();
      drive('0, '0);
   endtask

   task automatic fetch(input logic [31:0] addr, input logic [3:0] valid);
      ic_pkg::ic_access_t a;
      a         = '0;
      a.rw_addr = addr[31:2];
      a.rd_en   = 1'b1;
      drive(a, '0);
      tag_valid <= valid;
   endtask

   task automatic fill_line(input logic [31:0] line, input logic [1:0] way);
      ic_pkg::ic_access_t a;
      for (int b = 0; b < 8; b++) begin
         a         = '0;
         a.rw_addr = line[31:2] + 30'(2 * b);            // 8B beats
         a.wr_en   = 4'b1 << way;
         a.wr_data = 68'({$urandom, $urandom, $urandom});
         drive(a, '0);
      end
   endtask

   task automatic debug_access(input logic [31:0] addr, input logic [1:0] way,
                               input logic tag_sel, input logic wr,
                               input ic_pkg::ic_debug_word_u word);
      ic_pkg::ic_debug_t d;
      d           = '0;
      d.addr      = addr[11:2];
      d.rd_en     = ~wr;
      d.wr_en     = wr;
      d.tag_array = tag_sel;
      d.way       = 4'b1 << way;
      d.wr_data   = word;
      drive('0, d);
   endtask

   task automatic drain_checks(output bit drained);
      int cycles;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (kind_q != KIND_NONE && cycles < 20);
      drained = (kind_q == KIND_NONE);
   endtask

   initial begin : stimulus
      logic [31:0]            lines [$];
      logic [1:0]             ways [$];
      logic [31:0]            addr;
      logic [19:0]            new_tag;
      ic_pkg::ic_debug_word_u word;
      bit                     drained;
      void'($urandom(32'h5a70));
      clk       = 1'b0;
      rst_n     = 1'b0;
      acc       = '0;
      dbg       = '0;
      tag_valid = '0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      repeat (4) idle();                                // Outputs stay zero after reset

      for (int s = 0; s < 64; s++) begin                // Known tag in every entry
         for (int w = 0; w < 4; w++) begin
            debug_access({20'h0, 6'(s), 6'h0}, 2'(w), 1'b1, 1'b1,
                         tag_word(^INIT_TAG, INIT_TAG));
         end
      end

      for (int i = 0; i < 6; i++) begin                 // Lines in distinct sets
         lines.push_back({rand_tag(), 6'(i * 9 + 2), 6'h0});
         ways.push_back(2'($urandom));
         fill_line(lines[i], ways[i]);
      end
      foreach (lines[i]) begin                          // Back-to-back fetches
         for (int off = 0; off < 4; off++) begin
            fetch({lines[i][31:6], 2'(off), 2'($urandom), 2'b00}, 4'hf);
         end
      end
      idle();

      fetch({rand_tag(), lines[0][11:6], 6'h10}, 4'hf); // Tag never filled
      idle();
      fetch(lines[1] | 32'h24, 4'hf & ~(4'b1 << ways[1]));
      idle();

      addr      = {lines[2][31:6], 2'h1, 2'h2, 2'b00};
      word.data = 34'({$urandom, $urandom});
      debug_access(addr, ways[2], 1'b0, 1'b1, word);
      debug_access(addr, ways[2], 1'b0, 1'b0, '0);
      fetch({lines[2][31:6], 2'h1, 4'h0}, 4'hf);
      idle();

      new_tag = rand_tag();
      addr    = {20'h0, lines[3][11:6], 6'h0};
      debug_access(addr, ways[3], 1'b1, 1'b1, tag_word(^new_tag, new_tag));
      debug_access(addr, ways[3], 1'b1, 1'b0, '0);
      fetch({new_tag, lines[3][11:6], 6'h04}, 4'hf);
      debug_access(addr, ways[3], 1'b1, 1'b1, tag_word(~^new_tag, new_tag));
      fetch({new_tag, lines[3][11:6], 6'h08}, 4'hf);   // Bad parity on a valid way
      idle();
      fetch({new_tag, lines[3][11:6], 6'h08}, 4'hf & ~(4'b1 << ways[3]));
      idle();
      drain_checks(drained);
      if (drained) begin
         $display("all tests passed");
         $finish;
      end else begin
         $display("Timeout: read responses still pending after 20 cycles");
         $display("tests failed");
         $fatal(1, "Read pipeline did not drain");
      end
   end

endmodule

/* vlog.f */
+incdir+hdl
hdl/ic_pkg.sv
hdl/ic_sram.sv
hdl/ic_data_array.sv
hdl/ic_tag_array.sv
hdl/ic_mem.sv
testbench/tb_ic_mem.sv
